// ==== design/bus_master.sv ====
`timescale 1ns/10ps

module bus_master(
	input __clk,
	input arst_n,

	input [cpu_pkg::word_w-1:0] rdt,
	input ok,
	input en,
	input pe,
	output logic dr,
	output logic dw,
	output logic [cpu_pkg::word_w-1:0] dad,
	output logic [cpu_pkg::word_w-1:0] ddt,

	bus_req_if.master bus
);

	enum logic [1:0] {st_idle, st_strobe, st_release, st_done} state;

	logic [$clog2(cpu_pkg::bus_timeout)-1:0] cnt;
	wire cnt_last = cnt == ($bits(cnt))'(cpu_pkg::bus_timeout - 1);

	// --------------------------------------------------
	// Strobe and reply handshake
	// --------------------------------------------------

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			dr <= 1'b0;
			dw <= 1'b0;
			cnt <= '0;
			bus.nomem <= 1'b0;
			bus.parity <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (bus.req) begin
						dr <= !bus.write;
						dw <= bus.write;
						cnt <= '0;
						state <= st_strobe;
					end
				end
				st_strobe: begin
					if (ok) begin
						dr <= 1'b0;
						dw <= 1'b0;
						bus.nomem <= 1'b0;
						bus.parity <= pe & dr;
						state <= st_release;
					end else if (en || cnt_last) begin
						// Explicit no-memory reply or nobody there at all
						dr <= 1'b0;
						dw <= 1'b0;
						bus.nomem <= 1'b1;
						bus.parity <= 1'b0;
						state <= st_release;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_release: begin
					// Wait for the memory to let go of its reply
					if (!ok && !en) begin
						state <= st_done;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Address, write data and read data
	always_ff @(posedge __clk) begin
		if (state == st_idle && bus.req) begin
			dad <= bus.addr;
			ddt <= bus.wdata;
		end
		if (state == st_strobe && ok) begin
			bus.rdata <= rdt;
		end
	end

	assign bus.done = state == st_done;

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/10ps

module cpu(
	input __clk,
	input arst_n,

	// Control panel
	input [cpu_pkg::word_w-1:0] kl,
	input wac, war, wrs,
	input panel_store, panel_fetch,
	input clm,
	input rsa, rsb,
	output [cpu_pkg::word_w-1:0] w,
	output busy,
	output irq,

	// System bus
	output dr,
	output dw,
	output [cpu_pkg::word_w-1:0] dad,
	output [cpu_pkg::word_w-1:0] ddt,
	input [cpu_pkg::word_w-1:0] rdt,
	input ok,
	input en,
	input pe,
	input rin,
	input zegar
);

	bus_req_if bus_if();
	reg_ctrl_if reg_if();

	wire [cpu_pkg::irq_count-1:0] rz;
	wire [cpu_pkg::irq_count-1:0] rs;

	// --------------------------------------------------
	// Panel sequencing and registers
	// --------------------------------------------------

	panel_ctrl pm(.__clk(__clk), .arst_n(arst_n), .kl(kl), .wac(wac), .war(war),
		.panel_store(panel_store), .panel_fetch(panel_fetch), .clm(clm), .busy(busy),
		.bus(bus_if.ctrl), .regs(reg_if.ctrl));

	reg_file pa(.__clk(__clk), .arst_n(arst_n), .rsa(rsa), .rsb(rsb), .rz(rz), .rs(rs),
		.w(w), .regs(reg_if.regs));

	// --------------------------------------------------
	// Bus timing and interrupts
	// --------------------------------------------------

	bus_master px(.__clk(__clk), .arst_n(arst_n), .rdt(rdt), .ok(ok), .en(en), .pe(pe),
		.dr(dr), .dw(dw), .dad(dad), .ddt(ddt), .bus(bus_if.master));

	irq_ctrl pp(.__clk(__clk), .arst_n(arst_n), .kl(kl), .wrs(wrs), .clm(clm), .busy(busy),
		.rin(rin), .zegar(zegar), .irq(irq), .rz(rz), .rs(rs), .bus(bus_if.monitor));

endmodule

// ==== design/cpu_ifs.sv ====
`timescale 1ns/10ps

// --------------------------------------------------
// Bus cycle request between the panel and the bus timing
// --------------------------------------------------

interface bus_req_if;

	logic req;
	logic write;
	logic [cpu_pkg::word_w-1:0] addr;
	logic [cpu_pkg::word_w-1:0] wdata;
	logic [cpu_pkg::word_w-1:0] rdata;
	logic done;
	logic nomem;
	logic parity;

	// Requester holds req, write, addr and wdata until done
	modport ctrl(output req, write, addr, wdata, input rdata, done, nomem);

	// Status is valid only in the cycle of done
	modport master(input req, write, addr, wdata, output rdata, done, nomem, parity);

	// Interrupt logic only watches the end of each cycle
	modport monitor(input done, nomem, parity);

endinterface

// --------------------------------------------------
// Register load controls from the panel
// --------------------------------------------------

interface reg_ctrl_if;

	logic ld_ac;
	logic ld_ar;
	logic inc_ar;
	logic [cpu_pkg::word_w-1:0] ac_data;
	logic [cpu_pkg::word_w-1:0] ac;
	logic [cpu_pkg::word_w-1:0] ar;

	modport ctrl(output ld_ac, ld_ar, inc_ar, ac_data, input ac, ar);

	modport regs(input ld_ac, ld_ar, inc_ar, ac_data, output ac, ar);

endinterface

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

	// --------------------------------------------------
	// Word sizes
	// --------------------------------------------------

	localparam int word_w = 16;
	localparam int irq_count = 4;

	// Bit positions in rz and in the mask
	localparam int irq_nomem = 0;
	localparam int irq_parity = 1;
	localparam int irq_ext = 2;
	localparam int irq_clock = 3;

	// --------------------------------------------------
	// Display selector codes, {rsb, rsa}
	// --------------------------------------------------

	localparam logic [1:0] disp_ac = 2'd0;
	localparam logic [1:0] disp_ar = 2'd1;
	localparam logic [1:0] disp_rz = 2'd2;
	localparam logic [1:0] disp_rs = 2'd3;

	// Cycles with a strobe up and no reply before the cycle counts as no memory
	localparam int bus_timeout = 32;

endpackage

// ==== design/irq_ctrl.sv ====
`timescale 1ns/10ps

module irq_ctrl(
	input __clk,
	input arst_n,

	input [cpu_pkg::word_w-1:0] kl,
	input wrs,
	input clm,
	input busy,
	input rin,
	input zegar,
	output irq,
	output logic [cpu_pkg::irq_count-1:0] rz,
	output logic [cpu_pkg::irq_count-1:0] rs,

	bus_req_if.monitor bus
);

	logic [cpu_pkg::irq_count-1:0] events;

	// Requests raised in this cycle
	always_comb begin
		events = '0;
		events[cpu_pkg::irq_nomem] = bus.done & bus.nomem;
		events[cpu_pkg::irq_parity] = bus.done & bus.parity;
		events[cpu_pkg::irq_ext] = rin;
		events[cpu_pkg::irq_clock] = zegar;
	end

	// --------------------------------------------------
	// Request and mask registers
	// --------------------------------------------------

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			rz <= '0;
			rs <= '0;
		end else if (clm && !busy) begin
			rz <= '0;
			rs <= '0;
		end else begin
			// Bits stick until cleared from the panel
			rz <= rz | events;
			if (wrs && !busy) begin
				rs <= kl[cpu_pkg::irq_count-1:0];
			end
		end
	end

	assign irq = |(rz & rs);

endmodule

// ==== design/panel_ctrl.sv ====
`timescale 1ns/10ps

module panel_ctrl(
	input __clk,
	input arst_n,

	input [cpu_pkg::word_w-1:0] kl,
	input wac,
	input war,
	input panel_store,
	input panel_fetch,
	input clm,
	output busy,

	bus_req_if.ctrl bus,
	reg_ctrl_if.ctrl regs
);

	enum logic [1:0] {st_idle, st_bus, st_finish} state;

	// Direction of the bus cycle in progress
	logic cmd_write;

	wire start = panel_store | panel_fetch;

	// --------------------------------------------------
	// Command sequence
	// --------------------------------------------------

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			cmd_write <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					// Clear wins over a memory command in the same cycle
					if (start && !clm) begin
						cmd_write <= panel_store;
						state <= st_bus;
					end
				end
				st_bus: begin
					if (bus.done) begin
						state <= st_finish;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign busy = state != st_idle;

	// Address and data come straight from AR and AC, which stay put while busy
	assign bus.req = state == st_bus;
	assign bus.write = cmd_write;
	assign bus.addr = regs.ar;
	assign bus.wdata = regs.ac;

	// --------------------------------------------------
	// Register steering
	// --------------------------------------------------

	always_comb begin
		regs.ld_ac = 1'b0;
		regs.ld_ar = 1'b0;
		regs.inc_ar = 1'b0;
		regs.ac_data = kl;
		if (state == st_idle) begin
			if (clm) begin
				regs.ld_ac = 1'b1;
				regs.ld_ar = 1'b1;
				regs.ac_data = '0;
			end else begin
				regs.ld_ac = wac;
				regs.ld_ar = war;
			end
		end else if (state == st_bus && bus.done) begin
			// AR steps even when nobody answered
			regs.inc_ar = 1'b1;
			if (!cmd_write && !bus.nomem) begin
				regs.ld_ac = 1'b1;
				regs.ac_data = bus.rdata;
			end
		end
	end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps

module reg_file(
	input __clk,
	input arst_n,

	input rsa,
	input rsb,
	input [cpu_pkg::irq_count-1:0] rz,
	input [cpu_pkg::irq_count-1:0] rs,
	output logic [cpu_pkg::word_w-1:0] w,

	reg_ctrl_if.regs regs
);

	logic [cpu_pkg::word_w-1:0] ac;
	logic [cpu_pkg::word_w-1:0] ar;

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ac <= '0;
			ar <= '0;
		end else begin
			if (regs.ld_ac) begin
				ac <= regs.ac_data;
			end
			// Increment wraps at the top and a load wins over it
			if (regs.ld_ar) begin
				ar <= regs.ac_data;
			end else if (regs.inc_ar) begin
				ar <= ar + 1'b1;
			end
		end
	end

	assign regs.ac = ac;
	assign regs.ar = ar;

	// Display multiplexer
	always_comb begin
		case ({rsb, rsa})
			cpu_pkg::disp_ac: w = ac;
			cpu_pkg::disp_ar: w = ar;
			cpu_pkg::disp_rz: w = {{(cpu_pkg::word_w-cpu_pkg::irq_count){1'b0}}, rz};
			cpu_pkg::disp_rs: w = {{(cpu_pkg::word_w-cpu_pkg::irq_count){1'b0}}, rs};
			default: w = '0;
		endcase
	end

endmodule

// ==== dv/tb_cpu.sv ====
`timescale 1ns/10ps

module tb_cpu;

	typedef enum int {cmd_wac, cmd_war, cmd_wrs, cmd_clm, cmd_store, cmd_fetch,
		cmd_rin, cmd_zegar} cmd_t;

	logic __clk = 1'b0;
	logic arst_n, wac, war, wrs, panel_store, panel_fetch, clm, rsa, rsb;
	logic ok, en, pe, rin, zegar;
	logic [15:0] kl, rdt;
	wire [15:0] w, dad, ddt;
	wire busy, irq, dr, dw;

	// Reference state
	logic [15:0] m_ac, m_ar;
	logic [15:0] m_mem [64];
	logic [3:0] m_rz, m_rs;
	logic [15:0] mem [64];
	logic [31:0] addr_lfsr = 32'h1352;
	logic [31:0] delay_lfsr = 32'h1352;
	logic [1:0] first_sel = cpu_pkg::disp_ac;
	int check_req = 0;
	int check_ack = 0;

	cpu dut(.__clk(__clk), .arst_n(arst_n), .kl(kl), .wac(wac), .war(war), .wrs(wrs),
		.panel_store(panel_store), .panel_fetch(panel_fetch), .clm(clm), .rsa(rsa),
		.rsb(rsb), .w(w), .busy(busy), .irq(irq), .dr(dr), .dw(dw), .dad(dad), .ddt(ddt),
		.rdt(rdt), .ok(ok), .en(en), .pe(pe), .rin(rin), .zegar(zegar));

	always #5 __clk = ~__clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [15:0] rand_bits(inout logic [31:0] s, input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			s = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
			v = {v[14:0], s[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] fill_word(input logic [5:0] a);
		return {4'h5, a, ~a};
	endfunction

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------

	function automatic void model_cmd(input cmd_t cmd, input logic [15:0] key);
		case (cmd)
			cmd_wac: m_ac = key;
			cmd_war: m_ar = key;
			cmd_wrs: m_rs = key[cpu_pkg::irq_count-1:0];
			cmd_rin: m_rz[cpu_pkg::irq_ext] = 1'b1;
			cmd_zegar: m_rz[cpu_pkg::irq_clock] = 1'b1;
			cmd_clm: begin
				m_ac = '0;
				m_ar = '0;
				m_rz = '0;
				m_rs = '0;
			end
			default: begin
				// No memory at 64 and above whether en or the timeout ends the cycle
				if (m_ar >= 64) begin
					m_rz[cpu_pkg::irq_nomem] = 1'b1;
				end else if (cmd == cmd_store) begin
					m_mem[m_ar[5:0]] = m_ac;
				end else begin
					m_ac = m_mem[m_ar[5:0]];
					if (m_ar[5]) m_rz[cpu_pkg::irq_parity] = 1'b1;
				end
				m_ar = m_ar + 16'd1;
			end
		endcase
	endfunction

	function automatic logic [15:0] expected_word(input logic [1:0] sel);
		case (sel)
			cpu_pkg::disp_ac: return m_ac;
			cpu_pkg::disp_ar: return m_ar;
			cpu_pkg::disp_rz: return {12'h000, m_rz};
			default: return {12'h000, m_rs};
		endcase
	endfunction

	// --------------------------------------------------
	// Memory model and compare process
	// --------------------------------------------------

	initial begin : memory_model
		logic [15:0] a;
		logic [15:0] delay;
		int n;
		ok = 1'b0;
		en = 1'b0;
		pe = 1'b0;
		rdt = '0;
		for (int i = 0; i < 64; i++) mem[i] = fill_word(i[5:0]);
		forever begin
			@(posedge __clk);
			#1;
			if (dr || dw) begin
				a = dad;
				delay = rand_bits(delay_lfsr, 3);
				repeat (delay) begin
					@(posedge __clk);
					#1;
				end
				if (a < 64) begin
					ok = 1'b1;
					rdt = mem[a[5:0]];
					pe = dr & a[5];
					if (dw) mem[a[5:0]] = ddt;
				end else if (a < 128) begin
					en = 1'b1;
				end
				// Reply held until the strobe drops
				for (n = 0; dr || dw; n++) begin
					if (n == 100) abort_run("Bus strobe never dropped");
					@(posedge __clk);
					#1;
				end
				ok = 1'b0;
				en = 1'b0;
				pe = 1'b0;
			end
		end
	end

	initial begin : compare
		logic [1:0] sel;
		rsa = 1'b0;
		rsb = 1'b0;
		forever begin
			@(posedge __clk);
			if (check_ack != check_req) begin
				// Start with the register the command touched
				for (int i = 0; i < 4; i++) begin
					sel = i[1:0] + first_sel;
					#1;
					{rsb, rsa} = sel;
					@(negedge __clk);
					assert (w == expected_word(sel))
					else abort_run($sformatf("mismatch at %0t: display %0d shows %h, expected %h",
						$time, sel, w, expected_word(sel)));
					if (i < 3) @(posedge __clk);
				end
				assert (!busy && !dr && !dw)
				else abort_run($sformatf("mismatch at %0t: busy or strobe high when idle", $time));
				assert (irq == |(m_rz & m_rs))
				else abort_run($sformatf("mismatch at %0t: irq is %b", $time, irq));
				check_ack = check_req;
			end
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------

	task automatic await_check();
		for (int n = 0; check_ack != check_req; n++) begin
			if (n == 20) abort_run("Compare process did not finish");
			@(posedge __clk);
			#1;
		end
	endtask

	task automatic drive_pulse(input cmd_t cmd, input logic level);
		case (cmd)
			cmd_wac: wac = level;
			cmd_war: war = level;
			cmd_wrs: wrs = level;
			cmd_clm: clm = level;
			cmd_store: panel_store = level;
			cmd_fetch: panel_fetch = level;
			cmd_rin: rin = level;
			default: zegar = level;
		endcase
	endtask

	task automatic run_cmd(input cmd_t cmd, input logic [15:0] key);
		logic [15:0] addr;
		logic [15:0] data;
		logic mem_cmd;
		addr = m_ar;
		data = m_ac;
		mem_cmd = cmd == cmd_store || cmd == cmd_fetch;
		case (cmd)
			cmd_war: first_sel = cpu_pkg::disp_ar;
			cmd_wrs: first_sel = cpu_pkg::disp_rs;
			cmd_rin, cmd_zegar: first_sel = cpu_pkg::disp_rz;
			default: first_sel = cpu_pkg::disp_ac;
		endcase
		@(posedge __clk);
		#1;
		kl = key;
		drive_pulse(cmd, 1'b1);
		model_cmd(cmd, key);
		if (!mem_cmd) check_req++;
		@(posedge __clk);
		#1;
		drive_pulse(cmd, 1'b0);
		if (mem_cmd) begin
			assert (busy && !dr && !dw)
			else abort_run($sformatf("mismatch at %0t: busy low or strobe early",
				$time));
			// Panel pulses while busy
			kl = ~key;
			{wac, war, wrs, clm, panel_store, panel_fetch} = 6'h3f;
			@(posedge __clk);
			#1;
			{wac, war, wrs, clm, panel_store, panel_fetch} = 6'h00;
			assert (dr == (cmd == cmd_fetch) && dw == (cmd == cmd_store) && dad == addr
				&& (cmd == cmd_fetch || ddt == data))
			else abort_run($sformatf("mismatch at %0t: bus cycle start wrong", $time));
			for (int n = 0; busy; n++) begin
				if (n == 100) abort_run("Busy did not fall after a memory command");
				@(posedge __clk);
				#1;
			end
			check_req++;
		end
		await_check();
	endtask

	initial begin : stimulus
		logic [15:0] a;
		logic [15:0] d;
		{kl, wac, war, wrs, panel_store, panel_fetch, clm, rin, zegar} = '0;
		arst_n = 1'b0;
		{m_ac, m_ar, m_rz, m_rs} = '0;
		for (int i = 0; i < 64; i++) m_mem[i] = fill_word(i[5:0]);
		repeat (4) @(posedge __clk);
		#1;
		arst_n = 1'b1;
		check_req++;
		await_check();

		// Key loads, mask and interrupt lines
		run_cmd(cmd_war, 16'h0abc);
		run_cmd(cmd_wac, 16'h1234);
		run_cmd(cmd_wrs, 16'hfff6);
		run_cmd(cmd_zegar, '0);
		run_cmd(cmd_rin, '0);
		run_cmd(cmd_clm, '0);

		// Store then fetch back at random addresses
		for (int i = 0; i < 12; i++) begin
			a = rand_bits(addr_lfsr, 6);
			d = rand_bits(addr_lfsr, 16);
			run_cmd(cmd_war, a);
			run_cmd(cmd_wac, d);
			run_cmd(cmd_store, '0);
			run_cmd(cmd_wac, ~d);
			run_cmd(cmd_war, a);
			run_cmd(cmd_fetch, '0);
		end

		// Parity, en, timeout and AR wrap
		run_cmd(cmd_clm, '0);
		run_cmd(cmd_war, 16'h0021);
		run_cmd(cmd_fetch, '0);
		run_cmd(cmd_wrs, 16'h0002);
		run_cmd(cmd_war, 16'h0050);
		run_cmd(cmd_store, '0);
		run_cmd(cmd_clm, '0);
		run_cmd(cmd_wac, 16'h5a5a);
		run_cmd(cmd_war, 16'h0051);
		run_cmd(cmd_fetch, '0);
		run_cmd(cmd_clm, '0);
		run_cmd(cmd_wac, 16'ha5c3);
		run_cmd(cmd_war, 16'hffff);
		run_cmd(cmd_fetch, '0);
		run_cmd(cmd_wrs, 16'h0001);
		run_cmd(cmd_clm, '0);

		$display("Regression passed");
		$finish;
	end

endmodule

// ==== mera_cpu.f ====
design/cpu_pkg.sv
design/cpu_ifs.sv
design/panel_ctrl.sv
design/reg_file.sv
design/bus_master.sv
design/irq_ctrl.sv
design/cpu.sv
dv/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# A broken build or a nonzero exit status also counts as a failed run
verilator --binary --timing --top-module tb_cpu -f mera_cpu.f -o tb_cpu > sim.log 2>&1 \
	&& ./obj_dir/tb_cpu >> sim.log 2>&1 \
	|| echo "Regression failed" >> sim.log

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
